// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -Wno-fatal -j 0 --top-module accel_core_tb -f accel_core.f
	@out=$$(./obj_dir/Vaccel_core_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// File: accel_core.f
+incdir+test
rtl/accel_core_pkg.sv
rtl/accel_input_buffer.sv
rtl/accel_weight_buffer.sv
rtl/accel_dot_unit.sv
rtl/accel_output_buffer.sv
rtl/accel_core_mul_controller.sv
rtl/accel_core.sv
test/accel_core_tb.sv

// File: rtl/accel_core.sv
module accel_core (
    input  logic                                  Clock,
    input  logic                                  rst_n,
    input  logic                                  in_load,
    input  accel_core_pkg::t_vec                  in_data,
    input  logic                                  done_layer,
    input  logic                                  w_load,
    input  accel_core_pkg::t_weight_load          w_payload,
    output logic [2:0]                            slot_valid,
    output logic [2:0][accel_core_pkg::ACC_W-1:0] slot_value
);

    accel_core_pkg::t_metadata_inout   input_metadata;
    accel_core_pkg::t_metadata_weights w1_metadata;
    accel_core_pkg::t_metadata_weights w2_metadata;
    accel_core_pkg::t_metadata_weights w3_metadata;
    accel_core_pkg::t_buffer_sel       assign_m1;
    accel_core_pkg::t_buffer_sel       assign_m2;
    accel_core_pkg::t_dot_result       result_m1;
    accel_core_pkg::t_dot_result       result_m2;
    logic clear_m1;
    logic clear_m2;
    logic out_valid_m1;
    logic out_valid_m2;
    logic release_w1;
    logic release_w2;
    logic release_w3;
    logic clear_output;

    accel_input_buffer i_input_buffer (.*);

    // Every weight buffer sees the same payload and filters on its own sel
    accel_weight_buffer #(.MY_SEL(accel_core_pkg::W1)) i_weight_buffer_w1 (
        .Clock, .rst_n,
        .load        (w_load),
        .load_data   (w_payload),
        .release_buf (release_w1),
        .metadata    (w1_metadata)
    );

    accel_weight_buffer #(.MY_SEL(accel_core_pkg::W2)) i_weight_buffer_w2 (
        .Clock, .rst_n,
        .load        (w_load),
        .load_data   (w_payload),
        .release_buf (release_w2),
        .metadata    (w2_metadata)
    );

    accel_weight_buffer #(.MY_SEL(accel_core_pkg::W3)) i_weight_buffer_w3 (
        .Clock, .rst_n,
        .load        (w_load),
        .load_data   (w_payload),
        .release_buf (release_w3),
        .metadata    (w3_metadata)
    );

    accel_core_mul_controller i_mul_controller (.*);

    accel_dot_unit i_dot_unit_m1 (
        .Clock, .rst_n,
        .clear          (clear_m1),
        .assign_sel     (assign_m1),
        .input_metadata,
        .w1_metadata, .w2_metadata, .w3_metadata,
        .out_valid      (out_valid_m1),
        .result         (result_m1)
    );

    accel_dot_unit i_dot_unit_m2 (
        .Clock, .rst_n,
        .clear          (clear_m2),
        .assign_sel     (assign_m2),
        .input_metadata,
        .w1_metadata, .w2_metadata, .w3_metadata,
        .out_valid      (out_valid_m2),
        .result         (result_m2)
    );

    accel_output_buffer i_output_buffer (.*);

endmodule

// File: rtl/accel_core_mul_controller.sv
module accel_core_mul_controller (
    input  logic                                Clock,
    input  logic                                rst_n,
    input  accel_core_pkg::t_metadata_inout     input_metadata,
    input  accel_core_pkg::t_metadata_weights   w1_metadata,
    input  accel_core_pkg::t_metadata_weights   w2_metadata,
    input  accel_core_pkg::t_metadata_weights   w3_metadata,
    input  logic                                out_valid_m1,
    input  logic                                out_valid_m2,
    output logic                                clear_output,
    output logic                                clear_m1,
    output logic                                clear_m2,
    output accel_core_pkg::t_buffer_sel         assign_m1,
    output accel_core_pkg::t_buffer_sel         assign_m2,
    output logic                                release_w1,
    output logic                                release_w2,
    output logic                                release_w3
);

    logic [3:1]                  busy;      // In-use flags, indexed like W1..W3
    accel_core_pkg::t_buffer_sel m1_pick;
    accel_core_pkg::t_buffer_sel m1_take;   // Buffer M1 grabs this cycle, if any
    accel_core_pkg::t_buffer_sel m2_pick;
    accel_core_pkg::t_buffer_sel m1_next;
    accel_core_pkg::t_buffer_sel m2_next;
    logic                        in_use_q;

    // Lowest numbered loaded buffer that neither skip value names
    function automatic accel_core_pkg::t_buffer_sel pick_buffer(
        input logic [3:1]                  avail,
        input accel_core_pkg::t_buffer_sel skip_a,
        input accel_core_pkg::t_buffer_sel skip_b
    );
        if (avail[1] && skip_a != accel_core_pkg::W1 && skip_b != accel_core_pkg::W1)
            return accel_core_pkg::W1;
        if (avail[2] && skip_a != accel_core_pkg::W2 && skip_b != accel_core_pkg::W2)
            return accel_core_pkg::W2;
        if (avail[3] && skip_a != accel_core_pkg::W3 && skip_b != accel_core_pkg::W3)
            return accel_core_pkg::W3;
        return accel_core_pkg::FREE;
    endfunction

    assign busy = {w3_metadata.in_use, w2_metadata.in_use, w1_metadata.in_use};

    always_comb begin
        m1_pick = pick_buffer(busy, assign_m2, accel_core_pkg::FREE);
        m1_take = (assign_m1 == accel_core_pkg::FREE) ? m1_pick : accel_core_pkg::FREE;
        m2_pick = pick_buffer(busy, assign_m1, m1_take);  // M1 has priority
        m1_next = assign_m1;
        m2_next = assign_m2;
        if (!input_metadata.in_use_by_accel) begin
            // Layer over, drop both units
            m1_next = accel_core_pkg::FREE;
            m2_next = accel_core_pkg::FREE;
        end else begin
            if (out_valid_m1)
                m1_next = accel_core_pkg::FREE;
            else if (assign_m1 == accel_core_pkg::FREE)
                m1_next = m1_pick;
            if (out_valid_m2)
                m2_next = accel_core_pkg::FREE;
            else if (assign_m2 == accel_core_pkg::FREE)
                m2_next = m2_pick;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            assign_m1    <= accel_core_pkg::FREE;
            assign_m2    <= accel_core_pkg::FREE;
            clear_m1     <= 1'b1;
            clear_m2     <= 1'b1;
            in_use_q     <= 1'b0;
            clear_output <= 1'b0;
        end else begin
            assign_m1    <= m1_next;
            assign_m2    <= m2_next;
            clear_m1     <= (assign_m1 == accel_core_pkg::FREE);
            clear_m2     <= (assign_m2 == accel_core_pkg::FREE);
            in_use_q     <= input_metadata.in_use_by_accel;
            clear_output <= input_metadata.in_use_by_accel && !in_use_q;  // New layer
        end
    end

    // Free the buffer a unit held once its result is out
    assign release_w1 = (out_valid_m1 && assign_m1 == accel_core_pkg::W1) ||
                        (out_valid_m2 && assign_m2 == accel_core_pkg::W1);
    assign release_w2 = (out_valid_m1 && assign_m1 == accel_core_pkg::W2) ||
                        (out_valid_m2 && assign_m2 == accel_core_pkg::W2);
    assign release_w3 = (out_valid_m1 && assign_m1 == accel_core_pkg::W3) ||
                        (out_valid_m2 && assign_m2 == accel_core_pkg::W3);

    a_no_shared_buffer: assert property (@(posedge Clock) disable iff (!rst_n)
        assign_m1 == accel_core_pkg::FREE || assign_m1 != assign_m2);

    a_release_loaded: assert property (@(posedge Clock) disable iff (!rst_n)
        !(release_w1 && !w1_metadata.in_use) &&
        !(release_w2 && !w2_metadata.in_use) &&
        !(release_w3 && !w3_metadata.in_use));

endmodule

// File: rtl/accel_core_pkg.sv
package accel_core_pkg;

    localparam int VEC_LEN = 4;   // Elements per vector
    localparam int ELEM_W  = 8;   // Signed element width
    localparam int ACC_W   = 18;  // Signed accumulator width
    localparam int IDX_W   = $clog2(VEC_LEN);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(VEC_LEN - 1);

    // Names a weight buffer, FREE means none
    typedef enum logic [1:0] {
        FREE,
        W1,
        W2,
        W3
    } t_buffer_sel;

    typedef logic signed [ELEM_W-1:0] t_elem;
    typedef t_elem [VEC_LEN-1:0] t_vec;

    typedef struct packed {
        logic in_use_by_accel;
        t_vec data;
    } t_metadata_inout;

    typedef struct packed {
        logic in_use;
        t_vec data;
    } t_metadata_weights;

    // Host weight load payload
    typedef struct packed {
        t_buffer_sel sel;
        t_vec        data;
    } t_weight_load;

    // Finished dot product, tagged with the weight buffer it used
    typedef struct packed {
        t_buffer_sel              tag;
        logic signed [ACC_W-1:0]  value;
    } t_dot_result;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } t_dot_state;

endpackage

// File: rtl/accel_dot_unit.sv
module accel_dot_unit (
    input  logic                              Clock,
    input  logic                              rst_n,
    input  logic                              clear,
    input  accel_core_pkg::t_buffer_sel       assign_sel,
    input  accel_core_pkg::t_metadata_inout   input_metadata,
    input  accel_core_pkg::t_metadata_weights w1_metadata,
    input  accel_core_pkg::t_metadata_weights w2_metadata,
    input  accel_core_pkg::t_metadata_weights w3_metadata,
    output logic                              out_valid,
    output accel_core_pkg::t_dot_result       result
);

    accel_core_pkg::t_dot_state                state;
    logic [accel_core_pkg::IDX_W-1:0]          idx;
    logic signed [accel_core_pkg::ACC_W-1:0]   acc;
    logic signed [2*accel_core_pkg::ELEM_W-1:0] product;
    accel_core_pkg::t_vec                      weights;
    logic                                      abort;

    // Weight vector of the buffer this unit holds
    always_comb begin
        case (assign_sel)
            accel_core_pkg::W1: weights = w1_metadata.data;
            accel_core_pkg::W2: weights = w2_metadata.data;
            accel_core_pkg::W3: weights = w3_metadata.data;
            default:            weights = '0;
        endcase
    end

    assign product = $signed(input_metadata.data[idx]) * $signed(weights[idx]);
    assign abort   = clear || assign_sel == accel_core_pkg::FREE;  // Layer ended under us

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            state     <= accel_core_pkg::IDLE;
            idx       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                accel_core_pkg::IDLE: begin
                    idx <= '0;
                    if (!clear && assign_sel != accel_core_pkg::FREE)
                        state <= accel_core_pkg::RUN;
                end
                accel_core_pkg::RUN: begin
                    idx <= idx + 1'b1;
                    if (abort) begin
                        state <= accel_core_pkg::IDLE;
                    end else if (idx == accel_core_pkg::LAST_IDX) begin
                        state     <= accel_core_pkg::DONE;
                        out_valid <= 1'b1;   // Single pulse on entering DONE
                    end
                end
                accel_core_pkg::DONE: begin
                    if (clear)
                        state <= accel_core_pkg::IDLE;
                end
                default: state <= accel_core_pkg::IDLE;
            endcase
        end
    end

    // One product per RUN cycle
    always_ff @(posedge Clock) begin
        if (state == accel_core_pkg::IDLE)
            acc <= '0;
        else if (state == accel_core_pkg::RUN)
            acc <= acc + product;
    end

    assign result.tag   = assign_sel;
    assign result.value = acc;

    a_single_pulse: assert property (@(posedge Clock) disable iff (!rst_n)
        out_valid |=> !out_valid);

endmodule

// File: rtl/accel_input_buffer.sv
module accel_input_buffer (
    input  logic                            Clock,
    input  logic                            rst_n,
    input  logic                            in_load,
    input  accel_core_pkg::t_vec            in_data,
    input  logic                            done_layer,
    output accel_core_pkg::t_metadata_inout input_metadata
);

    logic                 in_use;
    accel_core_pkg::t_vec data;

    always_ff @(posedge Clock) begin
        if (!rst_n)
            in_use <= 1'b0;
        else if (in_load)
            in_use <= 1'b1;   // Held by the accelerator for the whole layer
        else if (done_layer)
            in_use <= 1'b0;
    end

    always_ff @(posedge Clock) begin
        if (in_load)
            data <= in_data;
    end

    assign input_metadata.in_use_by_accel = in_use;
    assign input_metadata.data            = data;

    a_load_vs_done: assert property (@(posedge Clock) disable iff (!rst_n)
        !(in_load && done_layer));

endmodule

// File: rtl/accel_output_buffer.sv
module accel_output_buffer (
    input  logic                                    Clock,
    input  logic                                    rst_n,
    input  logic                                    clear_output,
    input  logic                                    out_valid_m1,
    input  logic                                    out_valid_m2,
    input  accel_core_pkg::t_dot_result             result_m1,
    input  accel_core_pkg::t_dot_result             result_m2,
    output logic [2:0]                              slot_valid,
    output logic [2:0][accel_core_pkg::ACC_W-1:0]   slot_value
);

    logic [2:0] wr_m1;
    logic [2:0] wr_m2;

    // Slot write enable, bit 0 is W1
    function automatic logic [2:0] slot_hit(
        input logic                        valid,
        input accel_core_pkg::t_buffer_sel tag
    );
        logic [2:0] hit;
        case (tag)
            accel_core_pkg::W1: hit = 3'b001;
            accel_core_pkg::W2: hit = 3'b010;
            accel_core_pkg::W3: hit = 3'b100;
            default:            hit = 3'b000;  // Aborted run, nowhere to go
        endcase
        return valid ? hit : 3'b000;
    endfunction

    assign wr_m1 = slot_hit(out_valid_m1, result_m1.tag);
    assign wr_m2 = slot_hit(out_valid_m2, result_m2.tag);

    always_ff @(posedge Clock) begin
        if (!rst_n)
            slot_valid <= '0;
        else
            slot_valid <= (clear_output ? 3'b000 : slot_valid) | wr_m1 | wr_m2;
    end

    always_ff @(posedge Clock) begin
        for (int i = 0; i < 3; i++) begin
            if (wr_m1[i])
                slot_value[i] <= result_m1.value;
            else if (wr_m2[i])
                slot_value[i] <= result_m2.value;
        end
    end

    a_distinct_tags: assert property (@(posedge Clock) disable iff (!rst_n)
        !(out_valid_m1 && out_valid_m2 && result_m1.tag == result_m2.tag));

endmodule

// File: rtl/accel_weight_buffer.sv
module accel_weight_buffer #(
    parameter accel_core_pkg::t_buffer_sel MY_SEL = accel_core_pkg::W1
) (
    input  logic                              Clock,
    input  logic                              rst_n,
    input  logic                              load,
    input  accel_core_pkg::t_weight_load      load_data,
    input  logic                              release_buf,
    output accel_core_pkg::t_metadata_weights metadata
);

    logic                 in_use;
    logic                 take;
    accel_core_pkg::t_vec data;

    // Loads aimed at a busy buffer are dropped
    assign take = load && load_data.sel == MY_SEL && !in_use;

    always_ff @(posedge Clock) begin
        if (!rst_n)
            in_use <= 1'b0;
        else if (release_buf)
            in_use <= 1'b0;
        else if (take)
            in_use <= 1'b1;
    end

    always_ff @(posedge Clock) begin
        if (take)
            data <= load_data.data;
    end

    assign metadata.in_use = in_use;
    assign metadata.data   = data;

    a_release_when_busy: assert property (@(posedge Clock) disable iff (!rst_n)
        release_buf |-> in_use);

endmodule

// File: test/accel_core_tasks.svh
// Every task starts and returns just after a falling edge

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
        value_errors++;
        $display("Error: %s is %h, expected %h", name, got, expected);
    end
endtask

// Signed sum of element-wise products, cut to the accumulator width
function automatic logic [accel_core_pkg::ACC_W-1:0] dot_ref(
    input accel_core_pkg::t_vec a,
    input accel_core_pkg::t_vec b
);
    int sum = 0;
    for (int i = 0; i < accel_core_pkg::VEC_LEN; i++)
        sum += int'(a[i]) * int'(b[i]);
    return sum[accel_core_pkg::ACC_W-1:0];
endfunction

function automatic accel_core_pkg::t_vec rand_vec();
    accel_core_pkg::t_vec v;
    for (int i = 0; i < accel_core_pkg::VEC_LEN; i++)
        v[i] = accel_core_pkg::t_elem'($urandom_range(0, 255));
    return v;
endfunction

task automatic idle_cycles(input int n);
    repeat (n) @(negedge Clock);
endtask

// Ends the old layer, loads a new input vector and checks that the slots clear
task automatic start_layer(input accel_core_pkg::t_vec vec);
    done_layer = 1'b1;
    @(negedge Clock);
    done_layer = 1'b0;
    in_load    = 1'b1;
    in_data    = vec;
    @(negedge Clock);
    in_load = 1'b0;
    idle_cycles(3);   // clear_output, then the valid flags drop
    check_value("slot_valid", slot_valid, 3'b000);
endtask

task automatic load_weight(input accel_core_pkg::t_buffer_sel sel,
                           input accel_core_pkg::t_vec vec);
    w_load         = 1'b1;
    w_payload.sel  = sel;
    w_payload.data = vec;
    @(negedge Clock);
    w_load = 1'b0;
endtask

task automatic wait_slot(input int slot);
    int n = 0;
    while (!slot_valid[slot] && n < WAIT_LIMIT) begin
        @(negedge Clock);
        n++;
    end
    if (!slot_valid[slot]) begin
        wait_errors++;
        $display("Slot W%0d never became valid within %0d cycles", slot + 1, WAIT_LIMIT);
    end
endtask

task automatic run_full_layer(input accel_core_pkg::t_vec x,
                              input accel_core_pkg::t_vec w [3]);
    start_layer(x);
    for (int k = 0; k < 3; k++)
        load_weight(accel_core_pkg::t_buffer_sel'(k + 1), w[k]);  // Back to back
    for (int k = 0; k < 3; k++)
        wait_slot(k);
    for (int k = 0; k < 3; k++)
        check_value($sformatf("slot_value[%0d]", k), slot_value[k], dot_ref(x, w[k]));
endtask

task automatic test_idle_after_reset();
    for (int i = 0; i < 10; i++) begin
        check_value("slot_valid", slot_valid, 3'b000);
        @(negedge Clock);
    end
endtask

task automatic test_single_w1();
    accel_core_pkg::t_vec x;
    accel_core_pkg::t_vec w;
    x = {8'h03, 8'hfe, 8'h05, 8'h01};
    w = {8'h02, 8'h07, 8'hfd, 8'h04};
    start_layer(x);
    load_weight(accel_core_pkg::W1, w);
    wait_slot(0);
    check_value("slot_value[0]", slot_value[0], dot_ref(x, w));
    idle_cycles(5);
    check_value("slot_valid", slot_valid, 3'b001);
endtask

task automatic test_three_buffers();
    accel_core_pkg::t_vec w [3];
    for (int k = 0; k < 3; k++)
        w[k] = rand_vec();
    run_full_layer(rand_vec(), w);
endtask

task automatic test_busy_reload();
    accel_core_pkg::t_vec x;
    accel_core_pkg::t_vec first;
    accel_core_pkg::t_vec second;
    x      = {8'h05, 8'hfd, 8'h09, 8'h02};
    first  = {8'h11, 8'h22, 8'h33, 8'h44};
    second = {8'hf0, 8'h80, 8'h7f, 8'h05};
    start_layer(x);
    load_weight(accel_core_pkg::W2, first);
    load_weight(accel_core_pkg::W2, second);  // W2 busy, must be dropped
    wait_slot(1);
    check_value("slot_value[1]", slot_value[1], dot_ref(x, first));
    start_layer(x);
    load_weight(accel_core_pkg::W2, second);
    wait_slot(1);
    check_value("slot_value[1]", slot_value[1], dot_ref(x, second));
endtask

task automatic test_new_layer();
    accel_core_pkg::t_vec x;
    accel_core_pkg::t_vec w;
    x = rand_vec();
    w = rand_vec();
    check_value("slot_valid[1]", slot_valid[1], 1'b1);  // Left over from the last test
    start_layer(x);
    load_weight(accel_core_pkg::W3, w);
    wait_slot(2);
    check_value("slot_value[2]", slot_value[2], dot_ref(x, w));
    check_value("slot_valid", slot_valid, 3'b100);
endtask

task automatic test_random_rounds();
    accel_core_pkg::t_vec x;
    accel_core_pkg::t_vec w [3];
    for (int r = 0; r < 20; r++) begin
        x = rand_vec();
        for (int k = 0; k < 3; k++)
            w[k] = rand_vec();
        if (r == 0) begin
            x    = {4{8'h80}};
            w[0] = {4{8'h80}};   // Largest positive sum
            w[1] = {4{8'h7f}};
            w[2] = {8'h80, 8'h7f, 8'h80, 8'h7f};
        end else if (r == 1) begin
            x    = {4{8'h7f}};
            w[0] = {4{8'h7f}};
            w[1] = {4{8'h80}};
        end
        run_full_layer(x, w);
    end
endtask

// File: test/accel_core_tb.sv
module accel_core_tb;

    localparam int MAX_CYCLES = 2000;  // Tests need about 700 cycles
    localparam int WAIT_LIMIT = 40;    // Per result, worst case is about 2*VEC_LEN+8

    logic                                  Clock;
    logic                                  rst_n;
    logic                                  in_load;
    accel_core_pkg::t_vec                  in_data;
    logic                                  done_layer;
    logic                                  w_load;
    accel_core_pkg::t_weight_load          w_payload;
    logic [2:0]                            slot_valid;
    logic [2:0][accel_core_pkg::ACC_W-1:0] slot_value;

    int checks       = 0;
    int value_errors = 0;
    int wait_errors  = 0;
    int cycle_count  = 0;

    accel_core i_accel_core (.*);

    `include "accel_core_tasks.svh"

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    // Watchdog over the whole run
    always @(posedge Clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hc40598d6));
        rst_n      = 1'b0;
        in_load    = 1'b0;
        in_data    = '0;
        done_layer = 1'b0;
        w_load     = 1'b0;
        w_payload  = '0;
        repeat (2) @(negedge Clock);
        rst_n = 1'b1;

        test_idle_after_reset();
        test_single_w1();
        test_three_buffers();
        test_busy_reload();
        test_new_layer();
        test_random_rounds();

        $display("Checks: %0d, value errors: %0d, wait errors: %0d",
                 checks, value_errors, wait_errors);
        if (value_errors + wait_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
